//--- Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module gomoku_tb -f src.f
	./obj_dir/Vgomoku_tb | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- board_pkg.sv
`default_nettype none

`include "gomoku_macros.svh"

package board_pkg;

	// content of one board cell
	// the non-empty values also name the player
	typedef enum logic [1:0]
	{
		EMPTY      = 2'b00,
		PLAYER_ONE = 2'b01,
		PLAYER_TWO = 2'b10
	} cell_t;

	// cell coordinate, row 0 is the top row
	typedef struct packed
	{
		logic [`POS_W-1:0] row;
		logic [`POS_W-1:0] col;
	} grid_pos_t;

	// one stone to be placed
	typedef struct packed
	{
		grid_pos_t pos;
		cell_t     player;
	} move_t;

	// whole board, indexed [row][col]
	typedef cell_t [`GRID_SIZE-1:0][`GRID_SIZE-1:0] board_t;

endpackage

`default_nettype wire

//--- board_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "gomoku_macros.svh"

module board_store
	import board_pkg::*;
(
	input  logic   clock,
	input  logic   reset_n,
	input  logic   move_strobe,
	input  move_t  move,
	input  logic   game_over,
	output board_t board,
	output logic   move_accepted
);

	// cell under the incoming move
	cell_t target;
	logic  write_en;

	assign target = board[move.pos.row][move.pos.col];

	// only empty cells take a stone, and nothing changes once the game is won
	assign write_en = move_strobe && !game_over && (target == EMPTY);

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			// new game starts on a clear board
			for (int r = 0; r < `GRID_SIZE; r++)
			begin
				for (int c = 0; c < `GRID_SIZE; c++)
				begin
					board[r][c] <= EMPTY;
				end
			end
			move_accepted <= 1'b0;
		end
		else
		begin
			// pulse lines up with the first cycle the new stone is visible
			move_accepted <= write_en;
			if (write_en)
				board[move.pos.row][move.pos.col] <= move.player;
		end
	end

endmodule

`default_nettype wire

//--- gomoku_macros.svh
`ifndef GOMOKU_MACROS_SVH
`define GOMOKU_MACROS_SVH

// board edge in cells, the board is square
`define GRID_SIZE 7

// equal stones in a line needed to win
`define RUN_LENGTH 5

// bits of one row or column coordinate
`define POS_W 3

// seven segment patterns, active low, segment g is the msb
`define SEG_BLANK 7'b111_1111
// letter P
`define SEG_P 7'b000_1100
`define SEG_ONE 7'b111_1001
`define SEG_TWO 7'b010_0100

`endif

//--- gomoku_sva.sv
`timescale 1ns/1ns
`default_nettype none

`include "gomoku_macros.svh"

module gomoku_sva
	import board_pkg::*;
	import status_pkg::*;
(
	input logic      clock,
	input logic      reset_n,
	input logic      place_btn,
	input grid_pos_t cursor,
	input cell_t     turn,
	input logic      move_accepted,
	input winner_t   winner
);

	// running count of failed assertions
	int unsigned fail_count = 0;

	// accepted pulses never merge since presses are spaced
	assert property (@(posedge clock) disable iff (!reset_n)
		move_accepted |=> !move_accepted)
	else
	begin
		$error("move_accepted high in two cycles in a row");
		fail_count++;
	end

	// result sticks until reset
	assert property (@(posedge clock) disable iff (!reset_n)
		winner.valid |=> $stable(winner))
	else
	begin
		$error("winner changed after it became valid");
		fail_count++;
	end

	// cursor stays on the board
	assert property (@(posedge clock) disable iff (!reset_n)
		cursor.row < `GRID_SIZE && cursor.col < `GRID_SIZE)
	else
	begin
		$error("cursor left the board");
		fail_count++;
	end

	// turn moves only one cycle after a fresh place press
	assert property (@(posedge clock) disable iff (!reset_n)
		$changed(turn) |-> $past(place_btn) && !$past(place_btn, 2))
	else
	begin
		$error("turn changed without a place press");
		fail_count++;
	end

endmodule

bind gomoku_top gomoku_sva u_sva (
	.clock         (clock),
	.reset_n       (reset_n),
	.place_btn     (place_btn),
	.cursor        (cursor),
	.turn          (turn),
	.move_accepted (move_accepted),
	.winner        (winner)
);

`default_nettype wire

//--- gomoku_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "gomoku_macros.svh"

module gomoku_tb
	import board_pkg::*;
	import status_pkg::*;
();

	localparam int LEFT = 0;
	localparam int RIGHT = 1;
	localparam int PLACE = 2;
	localparam int CELLS = `GRID_SIZE * `GRID_SIZE;

	logic      clock;
	logic      reset_n;
	logic      left_btn;
	logic      right_btn;
	logic      place_btn;
	grid_pos_t cursor;
	cell_t     turn;
	logic      move_accepted;
	winner_t   winner;
	segments_t hex_player;
	segments_t hex_number;

	// reference model of the game
	cell_t     model_board [`GRID_SIZE][`GRID_SIZE];
	grid_pos_t exp_cursor;
	cell_t     exp_turn;
	logic      exp_accepted;
	winner_t   exp_winner;
	segments_t exp_hex_player;
	segments_t exp_hex_number;
	integer    seed;

	gomoku_top i_dut (
		.clock         (clock),
		.reset_n       (reset_n),
		.left_btn      (left_btn),
		.right_btn     (right_btn),
		.place_btn     (place_btn),
		.cursor        (cursor),
		.turn          (turn),
		.move_accepted (move_accepted),
		.winner        (winner),
		.hex_player    (hex_player),
		.hex_number    (hex_number)
	);

	initial
		clock = 1'b0;

	always #5 clock = ~clock;

	// digits as a player reads them: P and the winner number
	always_comb
	begin
		exp_hex_player = exp_winner.valid ? `SEG_P : `SEG_BLANK;
		exp_hex_number = `SEG_BLANK;
		if (exp_winner.valid)
			exp_hex_number = (exp_winner.player == PLAYER_ONE) ? `SEG_ONE : `SEG_TWO;
	end

	task automatic fail_run();
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("ERR time %0t %s got %0h expected %0h", $time, name, got, expected);
		fail_run();
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		fail_run();
	endtask

	// every edge outside reset, the DUT outputs match the model
	assert property (@(posedge clock) disable iff (!reset_n) cursor == exp_cursor)
	else
		report_mismatch("cursor", $sampled(cursor), $sampled(exp_cursor));

	assert property (@(posedge clock) disable iff (!reset_n) turn == exp_turn)
	else
		report_mismatch("turn", $sampled(turn), $sampled(exp_turn));

	assert property (@(posedge clock) disable iff (!reset_n) move_accepted == exp_accepted)
	else
		report_mismatch("move_accepted", $sampled(move_accepted), $sampled(exp_accepted));

	assert property (@(posedge clock) disable iff (!reset_n) winner == exp_winner)
	else
		report_mismatch("winner", $sampled(winner), $sampled(exp_winner));

	assert property (@(posedge clock) disable iff (!reset_n)
		hex_player == exp_hex_player && hex_number == exp_hex_number)
	else
		report_mismatch("hex_player,hex_number", {$sampled(hex_player), $sampled(hex_number)},
			{$sampled(exp_hex_player), $sampled(exp_hex_number)});

	// each call ends 1 ns after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	// a win counts stones through the new one along each of the four lines
	function automatic logic completes_run(input int r, input int c);
		int step_r [4] = '{0, 1, 1, 1};
		int step_c [4] = '{1, 0, 1, -1};
		int n;
		int rr;
		int cc;
		completes_run = 1'b0;
		for (int d = 0; d < 4; d++)
		begin
			n = 1;
			for (int s = -1; s <= 1; s += 2)
			begin
				rr = r + s * step_r[d];
				cc = c + s * step_c[d];
				while (rr >= 0 && rr < `GRID_SIZE && cc >= 0 && cc < `GRID_SIZE &&
					model_board[rr][cc] == model_board[r][c])
				begin
					n++;
					rr += s * step_r[d];
					cc += s * step_c[d];
				end
			end
			if (n >= `RUN_LENGTH)
				completes_run = 1'b1;
		end
	endfunction

	task automatic apply_reset();
		reset_n = 1'b0;
		exp_cursor = '0;
		exp_turn = PLAYER_ONE;
		exp_accepted = 1'b0;
		exp_winner = '0;
		for (int r = 0; r < `GRID_SIZE; r++)
		begin
			for (int c = 0; c < `GRID_SIZE; c++)
				model_board[r][c] = EMPTY;
		end
		idle_cycles(10);
		reset_n = 1'b1;
	endtask

	// one press: 2 cycles high, 2 low, then a random gap
	task automatic press(input int which);
		grid_pos_t   at;
		cell_t       mover;
		logic        take;
		logic [31:0] gap;
		int          idx;
		int          row_i;
		int          col_i;
		left_btn = (which == LEFT);
		right_btn = (which == RIGHT);
		place_btn = (which == PLACE);
		// press edge, cursor and turn move here
		idle_cycles(1);
		at = exp_cursor;
		mover = exp_turn;
		take = (which == PLACE) && model_board[at.row][at.col] == EMPTY && !exp_winner.valid;
		// cursor walks in reading order over the whole board
		idx = exp_cursor.row * `GRID_SIZE + exp_cursor.col;
		if (which == LEFT)
			idx = (idx + CELLS - 1) % CELLS;
		if (which == RIGHT)
			idx = (idx + 1) % CELLS;
		row_i = idx / `GRID_SIZE;
		col_i = idx % `GRID_SIZE;
		exp_cursor.row = row_i[`POS_W-1:0];
		exp_cursor.col = col_i[`POS_W-1:0];
		if (which == PLACE)
			exp_turn = (exp_turn == PLAYER_ONE) ? PLAYER_TWO : PLAYER_ONE;
		// stone lands one edge later
		idle_cycles(1);
		left_btn = 1'b0;
		right_btn = 1'b0;
		place_btn = 1'b0;
		if (take)
		begin
			exp_accepted = 1'b1;
			model_board[at.row][at.col] = mover;
		end
		// winner latches one edge after the stone
		idle_cycles(1);
		exp_accepted = 1'b0;
		if (take && completes_run(at.row, at.col))
		begin
			exp_winner.valid = 1'b1;
			exp_winner.player = mover;
		end
		gap = $random(seed);
		idle_cycles(1 + gap % 3);
	endtask

	// shortest walk to the cell, then place
	task automatic play(input int row, input int col);
		int here;
		int steps;
		here = exp_cursor.row * `GRID_SIZE + exp_cursor.col;
		steps = (row * `GRID_SIZE + col - here + CELLS) % CELLS;
		if (steps <= CELLS / 2)
			repeat (steps) press(RIGHT);
		else
			repeat (CELLS - steps) press(LEFT);
		press(PLACE);
	endtask

	task automatic wait_for_win(input cell_t who);
		int waited;
		waited = 0;
		while (!winner.valid)
		begin
			if (waited == 10)
				stop_run("no winner was reported within 10 cycles");
			idle_cycles(1);
			waited++;
		end
		if (exp_winner.player != who)
			stop_run("the game ended with a different winner than the scenario intends");
	endtask

	initial
	begin
		logic [31:0] rnd;
		seed = 32'h4d15c4b4;
		reset_n = 1'b0;
		left_btn = 1'b0;
		right_btn = 1'b0;
		place_btn = 1'b0;
		apply_reset();
		idle_cycles(4);
		// top left wraps to bottom right and back
		press(LEFT);
		press(RIGHT);
		repeat (40)
		begin
			rnd = $random(seed);
			press(rnd[0]);
		end
		// empty cell, then the same cell again, turn passes both times
		press(PLACE);
		press(PLACE);
		// player one fills row 0 while player two plays row 3
		apply_reset();
		for (int k = 0; k < 5; k++)
		begin
			play(0, k);
			if (k < 4)
				play(3, k);
		end
		wait_for_win(PLAYER_ONE);
		// board is frozen now
		play(5, 5);
		play(6, 6);
		// player two builds the down-left diagonal from the top right corner
		apply_reset();
		for (int k = 0; k < 5; k++)
		begin
			play(k < 4 ? 6 : 5, k < 4 ? k : 0);
			play(k, 6 - k);
		end
		wait_for_win(PLAYER_TWO);
		play(4, 4);
		play(5, 6);
		if (i_dut.u_sva.fail_count != 0)
		begin
			$display("%0d bound assertion failures were seen", i_dut.u_sva.fail_count);
			fail_run();
		end
		else
		begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- gomoku_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "gomoku_macros.svh"

module gomoku_top
	import board_pkg::*;
	import status_pkg::*;
(
	input  logic      clock,
	input  logic      reset_n,
	input  logic      left_btn,
	input  logic      right_btn,
	input  logic      place_btn,
	output grid_pos_t cursor,
	output cell_t     turn,
	output logic      move_accepted,
	output winner_t   winner,
	output segments_t hex_player,
	output segments_t hex_number
);

	// move path from button logic into the board
	move_t  move;
	logic   move_strobe;

	// board contents and the freeze signal back from the scanner
	board_t board;
	logic   game_over;

	move_entry u_move_entry (
		.clock       (clock),
		.reset_n     (reset_n),
		.left_btn    (left_btn),
		.right_btn   (right_btn),
		.place_btn   (place_btn),
		.cursor      (cursor),
		.turn        (turn),
		.move        (move),
		.move_strobe (move_strobe)
	);

	board_store u_board_store (
		.clock         (clock),
		.reset_n       (reset_n),
		.move_strobe   (move_strobe),
		.move          (move),
		.game_over     (game_over),
		.board         (board),
		.move_accepted (move_accepted)
	);

	win_scanner u_win_scanner (
		.clock         (clock),
		.reset_n       (reset_n),
		.board         (board),
		.move_accepted (move_accepted),
		.winner        (winner),
		.game_over     (game_over),
		.hex_player    (hex_player),
		.hex_number    (hex_number)
	);

endmodule

`default_nettype wire

//--- move_entry.sv
`timescale 1ns/1ns
`default_nettype none

`include "gomoku_macros.svh"

module move_entry
	import board_pkg::*;
(
	input  logic      clock,
	input  logic      reset_n,
	input  logic      left_btn,
	input  logic      right_btn,
	input  logic      place_btn,
	output grid_pos_t cursor,
	output cell_t     turn,
	output move_t     move,
	output logic      move_strobe
);

	// highest coordinate value on the board
	localparam int unsigned LAST_IDX = `GRID_SIZE - 1;
	localparam logic [`POS_W-1:0] LAST_POS = LAST_IDX[`POS_W-1:0];

	// button levels from the previous edge
	logic left_q;
	logic right_q;
	logic place_q;

	// single cycle press events
	logic left_press;
	logic right_press;
	logic place_press;

	grid_pos_t cursor_next;

	// rising level counts as a press, held buttons count once
	assign left_press  = left_btn & ~left_q;
	assign right_press = right_btn & ~right_q;
	assign place_press = place_btn & ~place_q;

	// cursor walks the board in reading order and wraps at both ends
	always_comb
	begin
		cursor_next = cursor;
		// left wins over right when both arrive together
		if (left_press)
		begin
			if (cursor.col != '0)
				cursor_next.col = cursor.col - 1'b1;
			else if (cursor.row != '0)
			begin
				cursor_next.col = LAST_POS;
				cursor_next.row = cursor.row - 1'b1;
			end
			else
			begin
				// top left corner wraps to bottom right
				cursor_next.col = LAST_POS;
				cursor_next.row = LAST_POS;
			end
		end
		else if (right_press)
		begin
			if (cursor.col != LAST_POS)
				cursor_next.col = cursor.col + 1'b1;
			else if (cursor.row != LAST_POS)
			begin
				cursor_next.col = '0;
				cursor_next.row = cursor.row + 1'b1;
			end
			else
			begin
				// bottom right corner wraps to top left
				cursor_next.col = '0;
				cursor_next.row = '0;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			left_q      <= 1'b0;
			right_q     <= 1'b0;
			place_q     <= 1'b0;
			cursor      <= '0;
			turn        <= PLAYER_ONE;
			move_strobe <= 1'b0;
		end
		else
		begin
			left_q      <= left_btn;
			right_q     <= right_btn;
			place_q     <= place_btn;
			cursor      <= cursor_next;
			move_strobe <= place_press;
			// the turn passes on every place press, even onto a taken cell
			if (place_press)
				turn <= (turn == PLAYER_ONE) ? PLAYER_TWO : PLAYER_ONE;
		end
	end

	// move payload, only looked at while move_strobe is high
	always_ff @(posedge clock)
	begin
		if (place_press)
		begin
			move.pos    <= cursor;
			move.player <= turn;
		end
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
board_pkg.sv
status_pkg.sv
move_entry.sv
board_store.sv
win_scanner.sv
gomoku_top.sv
gomoku_sva.sv
gomoku_tb.sv

//--- status_pkg.sv
`default_nettype none

package status_pkg;

	import board_pkg::*;

	// latched game result
	// player only means something once valid is set
	typedef struct packed
	{
		logic  valid;
		cell_t player;
	} winner_t;

	// one seven segment digit, active low
	// bit 6 is segment g, bit 0 is segment a
	typedef logic [6:0] segments_t;

endpackage

`default_nettype wire

//--- win_scanner.sv
`timescale 1ns/1ns
`default_nettype none

`include "gomoku_macros.svh"

module win_scanner
	import board_pkg::*;
	import status_pkg::*;
(
	input  logic      clock,
	input  logic      reset_n,
	input  board_t    board,
	input  logic      move_accepted,
	output winner_t   winner,
	output logic      game_over,
	output segments_t hex_player,
	output segments_t hex_number
);

	// scan directions: along a row, down a column,
	// down-right diagonal and down-left diagonal
	localparam int NUM_DIRS = 4;
	localparam int DIR_ROW [NUM_DIRS] = '{0, 1, 1, 1};
	localparam int DIR_COL [NUM_DIRS] = '{1, 0, 1, -1};

	// owner of the first complete window, EMPTY if none
	cell_t found;

	// owner of a run starting at (row, col) and stepping by (dr, dc)
	// gives EMPTY unless all cells match and are taken
	function automatic cell_t run_owner(input board_t b, input int row, input int col,
		input int dr, input int dc);
		cell_t first;
		logic  same;
		first = b[row][col];
		same  = (first != EMPTY);
		for (int k = 1; k < `RUN_LENGTH; k++)
		begin
			if (b[row + k * dr][col + k * dc] != first)
				same = 1'b0;
		end
		return same ? first : EMPTY;
	endfunction

	// 21 row, 21 column and 2 x 9 diagonal windows
	// a window is only tried when its last cell lies on the board
	always_comb
	begin
		int end_row;
		int end_col;
		found = EMPTY;
		for (int r = 0; r < `GRID_SIZE; r++)
		begin
			for (int c = 0; c < `GRID_SIZE; c++)
			begin
				for (int d = 0; d < NUM_DIRS; d++)
				begin
					end_row = r + (`RUN_LENGTH - 1) * DIR_ROW[d];
					end_col = c + (`RUN_LENGTH - 1) * DIR_COL[d];
					if (found == EMPTY && end_row < `GRID_SIZE && end_col >= 0 &&
						end_col < `GRID_SIZE)
						found = run_owner(board, r, c, DIR_ROW[d], DIR_COL[d]);
				end
			end
		end
	end

	// the board only changes with move_accepted, so scan results are taken then
	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			winner.valid  <= 1'b0;
			winner.player <= EMPTY;
		end
		else if (move_accepted && !winner.valid && found != EMPTY)
		begin
			// first winner sticks until the next reset
			winner.valid  <= 1'b1;
			winner.player <= found;
		end
	end

	// board_store stops taking moves once this is set
	assign game_over = winner.valid;

	// left digit shows P, right digit the player number
	always_comb
	begin
		hex_player = `SEG_BLANK;
		hex_number = `SEG_BLANK;
		if (winner.valid)
		begin
			hex_player = `SEG_P;
			case (winner.player)
				PLAYER_ONE: hex_number = `SEG_ONE;
				PLAYER_TWO: hex_number = `SEG_TWO;
				default:    hex_number = `SEG_BLANK;
			endcase
		end
	end

endmodule

`default_nettype wire
